//--- list.f
+incdir+design
design/nb_pkg.sv
design/edge_splitter.sv
design/line_bank.sv
design/neighbor_assembler.sv
design/intra_neighbor_top.sv
dv/intra_neighbor_tb.sv

//--- Makefile
# Verilator build and run for the intra neighbor stage
# Variables below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= intra_neighbor_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/intra_neighbor_tb.sv
//----------------------------------------
// Testbench for the intra neighbor stage.
// Runs random frames of 1, 3 and 7 MBs
// width, fetch then write per MB, and
// checks nb against a picture model.
//----------------------------------------
`include "nb_cfg.svh"

module intra_neighbor_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import nb_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int FRAMES       = 2;
    localparam int ROWS         = 3;
    localparam int PIC_WIDTHS [3] = '{1, 3, 7};
    localparam int TOTAL_MBS    = FRAMES * ROWS * (1 + 3 + 7);
    localparam int WATCHDOG_CYC = TOTAL_MBS * 12 + RESET_CYCLES + 100;
    // Widest field printed on a mismatch
    localparam int DW           = 160;

    logic       clk;
    logic       rst_n;
    logic       write;
    mb_pos_t    wr_pos;
    mb_edge_t   wr_edge;
    logic       read;
    mb_pos_t    rd_pos;
    logic       nb_valid;
    nb_set_t    nb;

    integer     seed;
    int         errors    = 0;
    int         fetches   = 0;
    int         responses = 0;
    logic [4:0] rd_hist   = '0;

    // Picture model: last bottom rows per column, last right columns
    mb_edge_t   col_model [0:(1<<`NB_MBX_BITS)-1];
    mb_edge_t   left_model;
    nb_set_t    exp_nb;

    intra_neighbor_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .write    (write),
        .wr_pos   (wr_pos),
        .wr_edge  (wr_edge),
        .read     (read),
        .rd_pos   (rd_pos),
        .nb_valid (nb_valid),
        .nb       (nb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Read strobe history, one bit per clock
    always @(posedge clk) begin
        rd_hist <= {rd_hist[3:0], read};
    end

    always @(negedge clk) begin
        if (nb_valid) begin
            responses++;
        end
    end

    task automatic flag_mismatch(input string name, input logic [DW-1:0] exp_v,
                                 input logic [DW-1:0] act_v);
        $display("MISMATCH %s expected %0h actual %0h at %0t", name, exp_v, act_v, $time);
        errors++;
    endtask

    //----------------------------------------
    // Checks, sampled on the falling edge
    //----------------------------------------
    a_valid_timing: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid == rd_hist[4])
        else flag_mismatch("nb_valid", DW'(rd_hist[4]), DW'(nb_valid));

    a_top_y: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.top_y == exp_nb.top_y))
        else flag_mismatch("top_y", DW'(exp_nb.top_y), DW'(nb.top_y));

    a_top_u: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.top_u == exp_nb.top_u))
        else flag_mismatch("top_u", DW'(exp_nb.top_u), DW'(nb.top_u));

    a_top_v: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.top_v == exp_nb.top_v))
        else flag_mismatch("top_v", DW'(exp_nb.top_v), DW'(nb.top_v));

    a_left_y: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.left_y == exp_nb.left_y))
        else flag_mismatch("left_y", DW'(exp_nb.left_y), DW'(nb.left_y));

    a_left_u: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.left_u == exp_nb.left_u))
        else flag_mismatch("left_u", DW'(exp_nb.left_u), DW'(nb.left_u));

    a_left_v: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.left_v == exp_nb.left_v))
        else flag_mismatch("left_v", DW'(exp_nb.left_v), DW'(nb.left_v));

    a_corner_y: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.corner_y == exp_nb.corner_y))
        else flag_mismatch("corner_y", DW'(exp_nb.corner_y), DW'(nb.corner_y));

    a_corner_u: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.corner_u == exp_nb.corner_u))
        else flag_mismatch("corner_u", DW'(exp_nb.corner_u), DW'(nb.corner_u));

    a_corner_v: assert property (@(negedge clk) disable iff (!rst_n)
        nb_valid |-> (nb.corner_v == exp_nb.corner_v))
        else flag_mismatch("corner_v", DW'(exp_nb.corner_v), DW'(nb.corner_v));

    //----------------------------------------
    // Stimulus and reference
    //----------------------------------------
    task automatic rand_edge(output mb_edge_t e);
        logic [$bits(mb_edge_t)-1:0] bits;
        for (int k = 0; k < $bits(mb_edge_t) / 32; k++) begin
            bits[32*k +: 32] = $random(seed);
        end
        e = mb_edge_t'(bits);
    endtask

    // Neighbor set from the availability rules and the model
    function automatic nb_set_t expect_nb(input mb_pos_t p);
        nb_set_t  e;
        mb_edge_t above;
        mb_edge_t prev;
        mb_edge_t next;
        logic     top_ok;
        logic     left_ok;
        logic     tr_ok;
        int       col;
        col     = int'(p.x);
        top_ok  = (p.y != '0);
        left_ok = (col > 0);
        tr_ok   = top_ok && (col + 1 < int'(p.w_mbs));
        above   = col_model[col];
        prev    = left_ok ? col_model[col-1] : '0;
        next    = tr_ok ? col_model[col+1] : '0;
        for (int i = 0; i < `NB_MB_PIX; i++) begin
            e.top_y[i]  = top_ok ? above.y_bottom[i] : pix_t'(`NB_TOP_DFLT);
            e.left_y[i] = left_ok ? left_model.y_right[i] : pix_t'(`NB_LEFT_DFLT);
        end
        for (int i = 0; i < `NB_C_PIX; i++) begin
            e.top_u[i]  = top_ok ? above.u_bottom[i] : pix_t'(`NB_TOP_DFLT);
            e.top_v[i]  = top_ok ? above.v_bottom[i] : pix_t'(`NB_TOP_DFLT);
            e.left_u[i] = left_ok ? left_model.u_right[i] : pix_t'(`NB_LEFT_DFLT);
            e.left_v[i] = left_ok ? left_model.v_right[i] : pix_t'(`NB_LEFT_DFLT);
        end
        // Top-right luma: next column, else repeat the last top pixel
        for (int i = 0; i < `NB_TR_PIX; i++) begin
            if (!top_ok) begin
                e.top_y[`NB_MB_PIX+i] = pix_t'(`NB_TOP_DFLT);
            end else if (tr_ok) begin
                e.top_y[`NB_MB_PIX+i] = next.y_bottom[i];
            end else begin
                e.top_y[`NB_MB_PIX+i] = above.y_bottom[`NB_MB_PIX-1];
            end
        end
        if (top_ok && left_ok) begin
            e.corner_y = prev.y_bottom[`NB_MB_PIX-1];
            e.corner_u = prev.u_bottom[`NB_C_PIX-1];
            e.corner_v = prev.v_bottom[`NB_C_PIX-1];
        end else begin
            e.corner_y = left_ok ? pix_t'(`NB_TOP_DFLT) : pix_t'(`NB_LEFT_DFLT);
            e.corner_u = e.corner_y;
            e.corner_v = e.corner_y;
        end
        return e;
    endfunction

    // One MB: fetch, wait for nb_valid, then write new edges
    task automatic run_mb(input int x, input int y, input int w);
        mb_pos_t  p;
        mb_edge_t e;
        p.x     = mbx_t'(x);
        p.y     = mby_t'(y);
        p.w_mbs = mbw_t'(w);
        exp_nb  = expect_nb(p);
        rd_pos  = p;
        read    = 1'b1;
        @(negedge clk);
        read = 1'b0;
        fetches++;
        while (!nb_valid) begin
            @(negedge clk);
        end
        rand_edge(e);
        wr_pos        = p;
        wr_edge       = e;
        write         = 1'b1;
        col_model[x]  = e;
        left_model    = e;
        @(negedge clk);
        write = 1'b0;
    endtask

    initial begin
        seed    = 32'h42b7_cc20;
        rst_n   = 1'b0;
        write   = 1'b0;
        wr_pos  = '0;
        wr_edge = '0;
        read    = 1'b0;
        rd_pos  = '0;
        left_model = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // Banks keep the old frame's rows, row 0 must still default
        foreach (PIC_WIDTHS[n]) begin
            for (int f = 0; f < FRAMES; f++) begin
                for (int y = 0; y < ROWS; y++) begin
                    for (int x = 0; x < PIC_WIDTHS[n]; x++) begin
                        run_mb(x, y, PIC_WIDTHS[n]);
                    end
                end
            end
        end

        repeat (8) @(negedge clk);
        if (responses != fetches) begin
            $display("Number of nb_valid pulses does not match the number of reads");
            errors++;
        end
        $display("Fetches %0d, responses %0d, errors %0d", fetches, responses, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout: simulation did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- design/intra_neighbor_top.sv
//----------------------------------------
// Neighbor-sample stage for 4:2:0 intra
// prediction. Write edges after each MB,
// strobe read before the next one; nb is
// valid 4 cycles after the read strobe.
//----------------------------------------
`include "nb_cfg.svh"

module intra_neighbor_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write,
    input  nb_pkg::mb_pos_t   wr_pos,
    input  nb_pkg::mb_edge_t  wr_edge,
    input  logic              read,
    input  nb_pkg::mb_pos_t   rd_pos,
    output logic              nb_valid,
    output nb_pkg::nb_set_t   nb
);
    import nb_pkg::*;

    logic                       bank_we;
    mbx_t                       bank_waddr;
    bank_word_t [`NB_BANKS-1:0] bank_wdata;
    logic                       bank_re;
    mbx_t                       bank_raddr;
    bank_word_t [`NB_BANKS-1:0] bank_rdata;
    fetch_phase_t               phase;
    logic                       phase_vld;
    mb_pos_t                    fetch_pos;
    mb_edge_t                   left_edge;

    edge_splitter u_splitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .write      (write),
        .wr_pos     (wr_pos),
        .wr_edge    (wr_edge),
        .read       (read),
        .rd_pos     (rd_pos),
        .bank_we    (bank_we),
        .bank_waddr (bank_waddr),
        .bank_wdata (bank_wdata),
        .bank_re    (bank_re),
        .bank_raddr (bank_raddr),
        .phase      (phase),
        .phase_vld  (phase_vld),
        .fetch_pos  (fetch_pos),
        .left_edge  (left_edge)
    );

    // Banks 0-1 luma, 2 U, 3 V
    for (genvar i = 0; i < `NB_BANKS; i++) begin : g_bank
        line_bank u_bank (
            .clk   (clk),
            .we    (bank_we),
            .waddr (bank_waddr),
            .wdata (bank_wdata[i]),
            .re    (bank_re),
            .raddr (bank_raddr),
            .rdata (bank_rdata[i])
        );
    end

    neighbor_assembler u_assembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .phase     (phase),
        .phase_vld (phase_vld),
        .fetch_pos (fetch_pos),
        .rdata     (bank_rdata),
        .left_edge (left_edge),
        .nb_valid  (nb_valid),
        .nb        (nb)
    );

endmodule

//--- design/neighbor_assembler.sv
//----------------------------------------
// Back end of the neighbor stage. Picks
// the corner, top and top-right samples
// out of the three bank reads, applies
// the availability rules, and presents
// the neighbor set with a nb_valid pulse.
//----------------------------------------
`include "nb_cfg.svh"

module neighbor_assembler (
    input  logic                                clk,
    input  logic                                rst_n,
    input  nb_pkg::fetch_phase_t                phase,
    input  logic                                phase_vld,
    input  nb_pkg::mb_pos_t                     fetch_pos,
    input  nb_pkg::bank_word_t [`NB_BANKS-1:0]  rdata,
    input  nb_pkg::mb_edge_t                    left_edge,
    output logic                                nb_valid,
    output nb_pkg::nb_set_t                     nb
);
    import nb_pkg::*;

    localparam pix_t top_dflt  = pix_t'(`NB_TOP_DFLT);
    localparam pix_t left_dflt = pix_t'(`NB_LEFT_DFLT);

    fetch_phase_t               phase_d;
    logic                       vld_d;
    pix_t                       corner_y_q;
    pix_t                       corner_u_q;
    pix_t                       corner_v_q;
    bank_word_t [`NB_BANKS-1:0] top_q;
    logic                       top_avail;
    logic                       left_avail;
    logic                       tr_avail;
    nb_set_t                    nb_next;

    //----------------------------------------
    // Availability
    //----------------------------------------
    assign top_avail  = (fetch_pos.y != '0);
    assign left_avail = (fetch_pos.x != '0);
    // Column to the right exists inside the picture
    assign tr_avail   = top_avail &&
                        ((mbw_t'(fetch_pos.x) + mbw_t'(1)) < fetch_pos.w_mbs);

    //----------------------------------------
    // Neighbor set built on the x+1 phase
    //----------------------------------------
    always_comb begin
        nb_next.left_y = left_avail ? left_edge.y_right : {`NB_MB_PIX{left_dflt}};
        nb_next.left_u = left_avail ? left_edge.u_right : {`NB_C_PIX{left_dflt}};
        nb_next.left_v = left_avail ? left_edge.v_right : {`NB_C_PIX{left_dflt}};

        if (top_avail) begin
            nb_next.top_y[`NB_BANK_PIX-1:0]           = top_q[0];
            nb_next.top_y[`NB_MB_PIX-1:`NB_BANK_PIX] = top_q[1];
            nb_next.top_u                             = top_q[2];
            nb_next.top_v                             = top_q[3];
        end else begin
            nb_next.top_y = {(`NB_MB_PIX+`NB_TR_PIX){top_dflt}};
            nb_next.top_u = {`NB_C_PIX{top_dflt}};
            nb_next.top_v = {`NB_C_PIX{top_dflt}};
        end

        // Top-right comes straight from the bank on this phase
        if (tr_avail) begin
            nb_next.top_y[`NB_MB_PIX +: `NB_TR_PIX] = rdata[0][`NB_TR_PIX-1:0];
        end else if (top_avail) begin
            nb_next.top_y[`NB_MB_PIX +: `NB_TR_PIX] =
                {`NB_TR_PIX{top_q[1][`NB_BANK_PIX-1]}};
        end

        if (left_avail && top_avail) begin
            nb_next.corner_y = corner_y_q;
            nb_next.corner_u = corner_u_q;
            nb_next.corner_v = corner_v_q;
        end else begin
            nb_next.corner_y = left_avail ? top_dflt : left_dflt;
            nb_next.corner_u = left_avail ? top_dflt : left_dflt;
            nb_next.corner_v = left_avail ? top_dflt : left_dflt;
        end
    end

    //----------------------------------------
    // Phase alignment and capture
    //----------------------------------------

    // Tag lags one cycle to meet the bank read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_d  <= PH_PREV;
            vld_d    <= 1'b0;
            nb_valid <= 1'b0;
        end else begin
            phase_d  <= phase;
            vld_d    <= phase_vld;
            nb_valid <= vld_d && (phase_d == PH_NEXT);
        end
    end

    always_ff @(posedge clk) begin
        if (vld_d) begin
            case (phase_d)
                PH_PREV: begin
                    // Last pixel of each stored bottom row at x-1
                    corner_y_q <= rdata[1][`NB_BANK_PIX-1];
                    corner_u_q <= rdata[2][`NB_BANK_PIX-1];
                    corner_v_q <= rdata[3][`NB_BANK_PIX-1];
                end
                PH_CUR: begin
                    top_q <= rdata;
                end
                default: begin
                    nb <= nb_next;
                end
            endcase
        end
    end

endmodule

//--- design/line_bank.sv
//----------------------------------------
// One slice of the line memory: 8 pixels
// per MB column. Synchronous write, read
// data registered one cycle after re.
//----------------------------------------
`include "nb_cfg.svh"

module line_bank (
    input  logic                clk,
    input  logic                we,
    input  nb_pkg::mbx_t        waddr,
    input  nb_pkg::bank_word_t  wdata,
    input  logic                re,
    input  nb_pkg::mbx_t        raddr,
    output nb_pkg::bank_word_t  rdata
);
    import nb_pkg::*;

    localparam int unsigned DEPTH = 1 << `NB_MBX_BITS;

    bank_word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port, output holds between reads
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- design/edge_splitter.sv
//----------------------------------------
// Front end of the neighbor stage. Takes
// the edges of each finished MB into the
// line banks and keeps the right columns
// as the next left edge. A read strobe
// starts three bank reads at x-1, x, x+1.
//----------------------------------------
`include "nb_cfg.svh"

module edge_splitter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                write,
    input  nb_pkg::mb_pos_t                     wr_pos,
    input  nb_pkg::mb_edge_t                    wr_edge,
    input  logic                                read,
    input  nb_pkg::mb_pos_t                     rd_pos,
    output logic                                bank_we,
    output nb_pkg::mbx_t                        bank_waddr,
    output nb_pkg::bank_word_t [`NB_BANKS-1:0]  bank_wdata,
    output logic                                bank_re,
    output nb_pkg::mbx_t                        bank_raddr,
    output nb_pkg::fetch_phase_t                phase,
    output logic                                phase_vld,
    output nb_pkg::mb_pos_t                     fetch_pos,
    output nb_pkg::mb_edge_t                    left_edge
);
    import nb_pkg::*;

    //----------------------------------------
    // Write path
    //----------------------------------------

    // Strobe and left edge registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_we   <= 1'b0;
            left_edge <= '0;
        end else begin
            bank_we <= write;
            if (write) begin
                left_edge <= wr_edge;
            end
        end
    end

    // Bottom rows cut into bank words; luma spans banks 0 and 1
    always_ff @(posedge clk) begin
        if (write) begin
            bank_waddr    <= wr_pos.x;
            bank_wdata[0] <= wr_edge.y_bottom[`NB_BANK_PIX-1:0];
            bank_wdata[1] <= wr_edge.y_bottom[2*`NB_BANK_PIX-1:`NB_BANK_PIX];
            bank_wdata[2] <= wr_edge.u_bottom;
            bank_wdata[3] <= wr_edge.v_bottom;
        end
    end

    //----------------------------------------
    // Fetch sequencer
    //----------------------------------------

    // Position is held for the assembler until the next strobe
    always_ff @(posedge clk) begin
        if (read) begin
            fetch_pos <= rd_pos;
        end
    end

    // Address wraps at the memory depth, out-of-picture reads are dropped later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= PH_PREV;
            phase_vld  <= 1'b0;
            bank_raddr <= '0;
        end else if (read) begin
            phase      <= PH_PREV;
            phase_vld  <= 1'b1;
            bank_raddr <= rd_pos.x - 1'b1;
        end else if (phase_vld) begin
            case (phase)
                PH_PREV: begin
                    phase      <= PH_CUR;
                    bank_raddr <= bank_raddr + 1'b1;
                end
                PH_CUR: begin
                    phase      <= PH_NEXT;
                    bank_raddr <= bank_raddr + 1'b1;
                end
                default: begin
                    phase     <= PH_PREV;
                    phase_vld <= 1'b0;
                end
            endcase
        end
    end

    // All banks are read together on every phase
    assign bank_re = phase_vld;

endmodule

//--- design/nb_pkg.sv
//----------------------------------------
// Types shared by the neighbor-sample
// stage: pixels, MB coordinates, edge and
// neighbor bundles, fetch phases.
//----------------------------------------
`include "nb_cfg.svh"

package nb_pkg;

    typedef logic [`NB_PIX_BITS-1:0] pix_t;
    typedef logic [`NB_MBX_BITS-1:0] mbx_t;
    typedef logic [`NB_MBY_BITS-1:0] mby_t;
    // One bit wider than mbx_t so a full-width picture fits
    typedef logic [`NB_MBX_BITS:0]   mbw_t;

    // Pixel 0 is the leftmost (or topmost) sample
    typedef pix_t [`NB_BANK_PIX-1:0] bank_word_t;

    typedef struct packed {
        mbx_t x;
        mby_t y;
        mbw_t w_mbs;
    } mb_pos_t;

    typedef struct packed {
        pix_t [`NB_MB_PIX-1:0] y_bottom;
        pix_t [`NB_MB_PIX-1:0] y_right;
        pix_t [`NB_C_PIX-1:0]  u_bottom;
        pix_t [`NB_C_PIX-1:0]  u_right;
        pix_t [`NB_C_PIX-1:0]  v_bottom;
        pix_t [`NB_C_PIX-1:0]  v_right;
    } mb_edge_t;

    typedef struct packed {
        pix_t [`NB_MB_PIX+`NB_TR_PIX-1:0] top_y;
        pix_t [`NB_C_PIX-1:0]             top_u;
        pix_t [`NB_C_PIX-1:0]             top_v;
        pix_t [`NB_MB_PIX-1:0]            left_y;
        pix_t [`NB_C_PIX-1:0]             left_u;
        pix_t [`NB_C_PIX-1:0]             left_v;
        pix_t                             corner_y;
        pix_t                             corner_u;
        pix_t                             corner_v;
    } nb_set_t;

    // Bank reads of a fetch, at columns x-1, x and x+1
    typedef enum logic [1:0] {
        PH_PREV = 2'd0,
        PH_CUR  = 2'd1,
        PH_NEXT = 2'd2
    } fetch_phase_t;

endpackage

//--- design/nb_cfg.svh
//----------------------------------------
// Build-time sizes for the intra neighbor
// stage. Include wherever a width, bank
// count or default sample is needed.
//----------------------------------------
`ifndef NB_CFG_SVH
`define NB_CFG_SVH

// Sample and picture geometry
`define NB_PIX_BITS   8
`define NB_MBX_BITS   7
`define NB_MBY_BITS   7
`define NB_MB_PIX     16
`define NB_C_PIX      8
`define NB_TR_PIX     4

// Line memory organisation
`define NB_BANKS      4
`define NB_BANK_PIX   8

// Substitutes for samples outside the picture
`define NB_TOP_DFLT   127
`define NB_LEFT_DFLT  129

`endif
